// File: source/st_pkg.sv
//##########################################################################
// shared constants and address type for the ST bus glue
// imported by every RTL module and interface of the core
//##########################################################################
package st_pkg;

	localparam int addr_w = 23; // cpu word address, a23..a1
	localparam int data_w = 16;

	// frame phases, one clk_8 each
	localparam logic [1:0] slot_video = 2'd0;
	localparam logic [1:0] slot_cpu   = 2'd1;
	localparam logic [1:0] slot_io    = 2'd2;
	localparam logic [1:0] slot_idle  = 2'd3;

	// mem_cfg codes
	localparam logic [2:0] mem_512k = 3'd0;
	localparam logic [2:0] mem_1m   = 3'd1;
	localparam logic [2:0] mem_2m   = 3'd2;
	localparam logic [2:0] mem_4m   = 3'd3;
	localparam logic [2:0] mem_8m   = 3'd4;
	localparam logic [2:0] mem_14m  = 3'd5;

	localparam logic [7:0]  io_page     = 8'hff;
	localparam logic [19:0] iack_prefix = 20'hfffff; // a23..a4 of an iack cycle

	// peripheral windows, byte offset inside the io page
	localparam logic [15:0] mmu_base  = 16'h8000;
	localparam logic [16:0] mmu_size  = 17'd2;
	localparam logic [15:0] vreg_base = 16'h8200;
	localparam logic [16:0] vreg_size = 17'd128;
	localparam logic [15:0] dma_base  = 16'h8600;
	localparam logic [16:0] dma_size  = 17'd16;
	localparam logic [15:0] psg_base  = 16'h8800;
	localparam logic [16:0] psg_size  = 17'd256;
	localparam logic [15:0] mfp_base  = 16'hfa00;
	localparam logic [16:0] mfp_size  = 17'd64;
	localparam logic [15:0] acia_base = 16'hfc00;
	localparam logic [16:0] acia_size = 17'd256;

	// bit positions in the one-hot select
	localparam int dev_mmu   = 0;
	localparam int dev_vreg  = 1;
	localparam int dev_dma   = 2;
	localparam int dev_psg   = 3;
	localparam int dev_mfp   = 4;
	localparam int dev_acia  = 5;
	localparam int dev_count = 6;

	// memory regions, byte addresses
	localparam logic [23:0] tos256k_lo = 24'he00000;
	localparam logic [23:0] tos256k_hi = 24'he3ffff;
	localparam logic [23:0] tos192k_lo = 24'hfc0000;
	localparam logic [23:0] tos192k_hi = 24'hfeffff;
	localparam logic [23:0] cart_lo    = 24'hfa0000;
	localparam logic [23:0] cart_hi    = 24'hfbffff;
	localparam logic [23:0] ram_bank   = 24'h400000; // 4 MB granule
	localparam logic [23:0] ram14_end  = 24'hdfffff;

	localparam logic [7:0] vec_vbi = 8'h1c;
	localparam logic [7:0] vec_hbi = 8'h1a;
	localparam logic [2:0] lvl_mfp = 3'd6;
	localparam logic [2:0] lvl_vbi = 3'd4;
	localparam logic [2:0] lvl_hbi = 3'd2;

	localparam logic [2:0] berr_limit = 3'd7; // cpu slots without dtack
	localparam logic [2:0] ipl_none   = 3'b111;

	typedef struct packed {
		logic [7:0]  page; // a23..a16
		logic [11:0] idx;  // a15..a4
		logic [2:0]  lvl;  // a3..a1, level on iack
	} addr_fields_t;

	// flat view for the memory map, field view for io and iack
	typedef union packed {
		logic [addr_w-1:0] word;
		addr_fields_t      io;
	} cpu_addr_u;

endpackage

// File: source/st_bus_if.sv
//##########################################################################
// cpu bus and device select bundles shared by the glue blocks
//##########################################################################
`timescale 1ns/100ps

interface cpu_bus_if import st_pkg::*; ();
	cpu_addr_u         addr;
	logic              as_n;  // address strobe, cycle request
	logic              uds_n;
	logic              lds_n;
	logic              rw;    // 1 = read
	logic [data_w-1:0] wdata;
	logic              strobe; // one cpu slot per sampled request

	// slot sequencer makes the strobe
	modport seq (
		input  as_n,
		output strobe
	);

	modport mon (
		input addr, as_n, uds_n, lds_n, rw, wdata, strobe
	);
endinterface

interface dev_sel_if import st_pkg::*; ();
	logic                 ram_hit;  // ram inside configured size
	logic                 mem_hit;  // anything memory-like that acks
	logic                 io_hit;
	logic                 iack_hit;
	logic [2:0]           iack_lvl;
	logic [dev_count-1:0] sel;      // strobe qualified, one-hot

	modport src (
		output ram_hit, mem_hit, io_hit, iack_hit, iack_lvl, sel
	);

	modport dst (
		input ram_hit, mem_hit, io_hit, iack_hit, iack_lvl, sel
	);
endinterface

// File: source/slot_sequencer.sv
//##########################################################################
// four phase frame counter on clk_8 and cpu request sampling
// strobe marks the cpu slot that may serve a pending address strobe
//##########################################################################
`timescale 1ns/100ps

module slot_sequencer import st_pkg::*; (
	input  logic       clk_8,
	input  logic       pll_locked,
	cpu_bus_if.seq     bus,
	output logic [1:0] slot
);

	logic [1:0] slot_nxt;

	always_comb begin
		case (slot)
			slot_video: slot_nxt = slot_cpu;
			slot_cpu:   slot_nxt = slot_io;
			slot_io:    slot_nxt = slot_idle;
			default:    slot_nxt = slot_video; // idle wraps
		endcase
	end

	// as_n only looked at during video, cpu gets the following slot
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			slot       <= slot_video;
			bus.strobe <= 1'b0;
		end else begin
			slot       <= slot_nxt;
			bus.strobe <= (slot == slot_video) && !bus.as_n;
		end
	end

	// strobe must line up with the ram interleave
	assert property (@(posedge clk_8) disable iff (!pll_locked)
		bus.strobe |-> (slot == slot_cpu));

endmodule

// File: source/addr_decode.sv
//##########################################################################
// combinational memory map of the cpu address
// ram size gating, rom and cartridge reads, io selects and iack level
//##########################################################################
`timescale 1ns/100ps

module addr_decode import st_pkg::*; (
	cpu_bus_if.mon     bus,
	input  logic [2:0] mem_cfg,
	dev_sel_if.src     dev
);

	logic [23:0]          byte_addr; // a23..a0, a0 always zero
	logic [15:0]          io_off;    // offset inside io page
	logic [23:0]          ram_top;   // first byte above installed ram
	logic                 ram14;
	logic                 rom;
	logic                 io_area;
	logic [dev_count-1:0] sel_raw;

	// window test, size may reach 64k
	function automatic logic in_win(
		input logic [15:0] off,
		input logic [15:0] base,
		input logic [16:0] size
	);
		logic [15:0] rel;
		rel = off - base;
		return (off >= base) && ({1'b0, rel} < size);
	endfunction

	assign byte_addr = {bus.addr.word, 1'b0};
	assign io_off    = {bus.addr.io.idx, bus.addr.io.lvl, 1'b0};

	// sizes below 4M still map the first bank
	always_comb begin
		case (mem_cfg)
			mem_512k,
			mem_1m,
			mem_2m,
			mem_4m:  ram_top = ram_bank;
			mem_8m:  ram_top = ram_bank << 1;
			mem_14m: ram_top = ram14_end + 24'd1;
			default: ram_top = ram_bank;
		endcase
	end

	assign ram14 = (byte_addr <= ram14_end); // reads ack even above ram_top
	assign rom   = ((byte_addr >= tos256k_lo) && (byte_addr <= tos256k_hi)) ||
	               ((byte_addr >= tos192k_lo) && (byte_addr <= tos192k_hi)) ||
	               ((byte_addr >= cart_lo) && (byte_addr <= cart_hi));

	assign dev.ram_hit = (byte_addr < ram_top);
	assign dev.mem_hit = ram14 || (bus.rw && rom); // rom never acks a write

	assign io_area = (bus.addr.io.page == io_page);

	assign sel_raw[dev_mmu]  = io_area && in_win(io_off, mmu_base, mmu_size);
	assign sel_raw[dev_vreg] = io_area && in_win(io_off, vreg_base, vreg_size);
	assign sel_raw[dev_dma]  = io_area && in_win(io_off, dma_base, dma_size);
	assign sel_raw[dev_psg]  = io_area && in_win(io_off, psg_base, psg_size);
	assign sel_raw[dev_mfp]  = io_area && in_win(io_off, mfp_base, mfp_size);
	assign sel_raw[dev_acia] = io_area && in_win(io_off, acia_base, acia_size);

	assign dev.io_hit = |sel_raw;
	assign dev.sel    = bus.strobe ? sel_raw : '0; // single cycle selects

	// 0xfffff0..f, level in a3..a1
	assign dev.iack_hit = ({bus.addr.io.page, bus.addr.io.idx} == iack_prefix);
	assign dev.iack_lvl = bus.addr.io.lvl;

	// peripheral windows must not overlap
	always_comb begin
		assert ($onehot0(sel_raw))
			else $error("overlapping io selects %b", sel_raw);
	end

endmodule

// File: source/bus_response.sv
//##########################################################################
// dtack handshake towards the cpu, read data capture and bus error timer
// answers in the cpu slot, holds dtack until the address strobe is gone
//##########################################################################
`timescale 1ns/100ps

module bus_response import st_pkg::*; (
	input  logic              clk_8,
	input  logic              pll_locked,
	cpu_bus_if.mon            bus,
	dev_sel_if.dst            dev,
	input  logic              br,        // other master wants the bus
	input  logic              clr_berr,
	input  logic [data_w-1:0] ram_rdata,
	input  logic [data_w-1:0] io_rdata,
	input  logic [7:0]        vector,
	output logic              dtack_n,
	output logic              berr,
	output logic [data_w-1:0] cpu_rdata,
	output logic              ram_rd,
	output logic              ram_wr
);

	logic       iack_ok; // levels that get an answer
	logic       hit;
	logic       req;
	logic       ack;
	logic [2:0] to_cnt;  // cpu slots spent waiting

	assign iack_ok = dev.iack_hit && ((dev.iack_lvl == lvl_mfp) ||
	                                  (dev.iack_lvl == lvl_vbi) ||
	                                  (dev.iack_lvl == lvl_hbi));
	assign hit = dev.mem_hit || dev.io_hit || iack_ok;

	// fresh cpu slot of an open, unanswered cycle
	assign req = bus.strobe && !bus.as_n && dtack_n && !br && !berr;
	assign ack = req && hit;

	assign ram_rd = req && dev.mem_hit && bus.rw;
	assign ram_wr = req && dev.ram_hit && !bus.rw && !(bus.uds_n && bus.lds_n);

	assign berr = (to_cnt == berr_limit);

	// four phase: fall on ack, rise once as_n seen high
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			dtack_n <= 1'b1;
		end else if (dtack_n) begin
			if (ack)
				dtack_n <= 1'b0;
		end else if (bus.as_n) begin
			dtack_n <= 1'b1;
		end
	end

	// ram data, or io data merged with the autovector
	always_ff @(posedge clk_8) begin
		if (ack)
			cpu_rdata <= dev.mem_hit ? ram_rdata : (io_rdata | {{(data_w-8){1'b0}}, vector});
	end

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			to_cnt <= '0;
		end else if (berr) begin
			if (clr_berr) // held until the cpu takes the fault
				to_cnt <= '0;
		end else if (br || bus.as_n || !dtack_n) begin
			to_cnt <= '0;
		end else if (bus.strobe && !hit) begin
			to_cnt <= to_cnt + 3'd1; // nobody home
		end
	end

	assert property (@(posedge clk_8) disable iff (!pll_locked)
		!(!dtack_n && berr));

	// write data has to stay put while the acked write is still open
	assert property (@(posedge clk_8) disable iff (!pll_locked)
		(!dtack_n && !bus.rw && !bus.as_n) |=> (bus.as_n || $stable(bus.wdata)));

endmodule

// File: source/irq_ctrl.sv
//##########################################################################
// blank interrupts and processor priority level
// vbi and hbi latch on blank edges, autovectors served on iack
//##########################################################################
`timescale 1ns/100ps

module irq_ctrl import st_pkg::*; (
	input  logic       clk_8,
	input  logic       pll_locked,
	cpu_bus_if.mon     bus,
	dev_sel_if.dst     dev,
	input  logic       vs,
	input  logic       hs,
	input  logic       mfp_irq,
	output logic [2:0] ipl,      // active low level to the cpu
	output logic [7:0] vector,
	output logic       mfp_iack
);

	// index 0 vbi, 1 hbi
	logic [1:0][2:0] blank_q; // two sync flops plus edge history
	logic [1:0]      blank_in;
	logic [1:0]      blank_rise;
	logic [1:0]      blank_ack;
	logic [1:0]      pend;
	logic            iack_cyc;

	assign blank_in = {hs, vs};
	assign iack_cyc = bus.strobe && dev.iack_hit;

	assign blank_ack[0] = iack_cyc && (dev.iack_lvl == lvl_vbi);
	assign blank_ack[1] = iack_cyc && (dev.iack_lvl == lvl_hbi);
	assign mfp_iack     = iack_cyc && (dev.iack_lvl == lvl_mfp); // mfp supplies its own vector

	always_comb begin
		for (int i = 0; i < 2; i++)
			blank_rise[i] = blank_q[i][1] && !blank_q[i][2];
	end

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			blank_q <= '0;
			pend    <= '0;
			ipl     <= ipl_none;
		end else begin
			for (int i = 0; i < 2; i++) begin
				blank_q[i] <= {blank_q[i][1:0], blank_in[i]};
				if (blank_ack[i])
					pend[i] <= 1'b0; // ack wins over a new edge
				else if (blank_rise[i])
					pend[i] <= 1'b1;
			end

			// mfp > vbi > hbi, ipl is the inverted level
			if (mfp_irq)
				ipl <= ~lvl_mfp;
			else if (pend[0])
				ipl <= ~lvl_vbi;
			else if (pend[1])
				ipl <= ~lvl_hbi;
			else
				ipl <= ipl_none;
		end
	end

	// st blank interrupts are autovectored
	always_comb begin
		vector = 8'h00;
		if (blank_ack[0])
			vector = vec_vbi;
		else if (blank_ack[1])
			vector = vec_hbi;
	end

	for (genvar i = 0; i < 2; i++) begin : g_pend_chk
		assert property (@(posedge clk_8) disable iff (!pll_locked)
			$fell(pend[i]) |-> $past(blank_ack[i]));
	end

endmodule

// File: source/st_glue.sv
//##########################################################################
// top of the cpu bus glue, plain pins towards cpu, ram and peripherals
// only instances and interface wiring live here
//##########################################################################
`timescale 1ns/100ps

module st_glue import st_pkg::*; (
	input  logic              clk_8,
	input  logic              pll_locked,
	input  logic [addr_w-1:0] cpu_addr,   // a23..a1
	input  logic              cpu_as_n,
	input  logic              cpu_uds_n,
	input  logic              cpu_lds_n,
	input  logic              cpu_rw,
	input  logic [data_w-1:0] cpu_wdata,
	output logic [data_w-1:0] cpu_rdata,
	output logic              dtack_n,
	output logic              berr,
	input  logic              clr_berr,
	output logic [2:0]        ipl,
	input  logic [2:0]        mem_cfg,
	input  logic              br,
	output logic              ram_rd,
	output logic              ram_wr,
	input  logic [data_w-1:0] ram_rdata,
	output logic              sel_mmu,
	output logic              sel_vreg,
	output logic              sel_dma,
	output logic              sel_psg,
	output logic              sel_mfp,
	output logic              sel_acia,
	input  logic [data_w-1:0] io_rdata,   // or'ed peripheral read data
	input  logic              mfp_irq,
	output logic              mfp_iack,
	input  logic              vs,
	input  logic              hs
);

	logic [7:0] vector; // autovector into the read mux

	cpu_bus_if bus ();
	dev_sel_if dev ();

	assign bus.addr.word = cpu_addr;
	assign bus.as_n      = cpu_as_n;
	assign bus.uds_n     = cpu_uds_n;
	assign bus.lds_n     = cpu_lds_n;
	assign bus.rw        = cpu_rw;
	assign bus.wdata     = cpu_wdata;

	assign sel_mmu  = dev.sel[dev_mmu];
	assign sel_vreg = dev.sel[dev_vreg];
	assign sel_dma  = dev.sel[dev_dma];
	assign sel_psg  = dev.sel[dev_psg];
	assign sel_mfp  = dev.sel[dev_mfp];
	assign sel_acia = dev.sel[dev_acia];

	slot_sequencer u_seq (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.bus        (bus),
		.slot       ()
	);

	addr_decode u_dec (
		.bus     (bus),
		.mem_cfg (mem_cfg),
		.dev     (dev)
	);

	bus_response u_resp (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.bus        (bus),
		.dev        (dev),
		.br         (br),
		.clr_berr   (clr_berr),
		.ram_rdata  (ram_rdata),
		.io_rdata   (io_rdata),
		.vector     (vector),
		.dtack_n    (dtack_n),
		.berr       (berr),
		.cpu_rdata  (cpu_rdata),
		.ram_rd     (ram_rd),
		.ram_wr     (ram_wr)
	);

	irq_ctrl u_irq (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.bus        (bus),
		.dev        (dev),
		.vs         (vs),
		.hs         (hs),
		.mfp_irq    (mfp_irq),
		.ipl        (ipl),
		.vector     (vector),
		.mfp_iack   (mfp_iack)
	);

endmodule

// File: include/tb_tasks.svh
//##########################################################################
// bus cycle helpers and directed tests, included inside tb_st_glue
//##########################################################################

task automatic report_value(input string test, input logic [31:0] expv,
		input logic [31:0] actv);
	val_errs++;
	$display("[ERROR] %s expected 0x%0h actual 0x%0h", test, expv, actv);
endtask

task automatic report_fail(input string msg);
	other_errs++;
	$display("%0t ns: %s", $time, msg);
endtask

// called on each falling edge of an open cycle
task automatic sample_outputs();
	if (ram_wr)
		n_wr++;
	if (ram_rd)
		n_rd++;
	if (|sel_vec)
		n_sel++;
	if (mfp_iack)
		n_iack++;
	if (berr)
		seen_berr = 1'b1;
	sel_seen = sel_seen | sel_vec;
endtask

// address and direction first, as_n one edge later
task automatic start_cycle(input logic [23:0] byte_addr, input logic rd,
		input logic [15:0] wdata);
	n_wr      = 0;
	n_rd      = 0;
	n_sel     = 0;
	n_iack    = 0;
	sel_seen  = 6'b000000;
	seen_berr = 1'b0;
	@(negedge clk_8);
	cpu_addr  = byte_addr[23:1];
	cpu_rw    = rd;
	cpu_wdata = wdata;
	cpu_uds_n = 1'b0; // both byte lanes
	cpu_lds_n = 1'b0;
	@(negedge clk_8);
	cpu_as_n = 1'b0;
endtask

// stops on dtack, on berr or after limit edges
task automatic wait_ack(input int limit, output logic acked, output logic [15:0] rdata);
	int n;
	acked = 1'b0;
	rdata = 16'h0000;
	n     = 0;
	while (!acked && !seen_berr && n < limit) begin
		@(negedge clk_8);
		sample_outputs();
		if (!dtack_n) begin
			acked = 1'b1;
			rdata = cpu_rdata; // valid while dtack_n is low
		end
		n++;
	end
endtask

task automatic end_cycle();
	int n;
	cpu_as_n = 1'b1;
	n        = 0;
	while (!dtack_n && n < 8) begin
		@(negedge clk_8);
		sample_outputs();
		n++;
	end
	if (!dtack_n)
		report_fail("dtack_n stayed low after as_n rose");
	cpu_uds_n = 1'b1;
	cpu_lds_n = 1'b1;
endtask

task automatic bus_cycle(input logic [23:0] byte_addr, input logic rd,
		input logic [15:0] wdata, input int limit, output logic acked,
		output logic [15:0] rdata);
	start_cycle(byte_addr, rd, wdata);
	wait_ack(limit, acked, rdata);
	end_cycle();
endtask

task automatic wait_ipl(input logic [2:0] expv, input string test);
	int n;
	n = 0;
	while (ipl !== expv && n < 16) begin
		@(negedge clk_8);
		n++;
	end
	if (ipl !== expv)
		report_value(test, 32'(expv), 32'(ipl));
endtask

task automatic clear_berr();
	int n;
	clr_berr = 1'b1;
	n        = 0;
	while (berr && n < 4) begin
		@(negedge clk_8);
		n++;
	end
	clr_berr = 1'b0;
	if (berr)
		report_fail("berr stayed high while clr_berr was set");
endtask

// byte address of each peripheral base in the io page
function automatic logic [23:0] io_addr(input int i);
	case (i)
		0:       return 24'hff8000;
		1:       return 24'hff8200;
		2:       return 24'hff8600;
		3:       return 24'hff8800;
		4:       return 24'hfffa00;
		default: return 24'hfffc00;
	endcase
endfunction

task automatic reset_state();
	if (dtack_n !== 1'b1)
		report_value("reset dtack_n", 32'd1, 32'(dtack_n));
	if (berr !== 1'b0)
		report_value("reset berr", 32'd0, 32'(berr));
	if (ipl !== 3'b111)
		report_value("reset ipl", 32'h7, 32'(ipl));
	if (sel_vec !== 6'b000000)
		report_value("reset sel", 32'd0, 32'(sel_vec));
	if ({ram_rd, ram_wr} !== 2'b00)
		report_value("reset ram_rd ram_wr", 32'd0, 32'({ram_rd, ram_wr}));
	if (mfp_iack !== 1'b0)
		report_value("reset mfp_iack", 32'd0, 32'(mfp_iack));
endtask

task automatic ram_access();
	logic [31:0] rnd;
	logic [23:0] a;
	logic [15:0] r;
	logic        ok;
	@(negedge clk_8);
	mem_cfg = mem_512k;
	for (int k = 0; k < 4; k++) begin
		rnd = $urandom;
		a   = rnd[23:0] & 24'h07fffe; // inside the first 512k
		bus_cycle(a, 1'b0, rnd[31:16], 8, ok, r);
		if (!ok)
			report_fail("ram write got no dtack");
		if (n_wr != 1)
			report_value("ram_access ram_wr pulses", 32'd1, n_wr);
		bus_cycle(a, 1'b1, 16'h0000, 8, ok, r);
		if (!ok)
			report_fail("ram read got no dtack");
		if (n_rd != 1)
			report_value("ram_access ram_rd pulses", 32'd1, n_rd);
		if (r !== ram_pattern(a[23:1]))
			report_value("ram_access read data", 32'(ram_pattern(a[23:1])), 32'(r));
	end
endtask

task automatic mem_size_and_rom();
	logic [15:0] r;
	logic        ok;
	@(negedge clk_8);
	mem_cfg = mem_512k;
	bus_cycle(24'h800000, 1'b0, 16'h1234, 8, ok, r); // above installed ram
	if (!ok)
		report_fail("write at 8 MB got no dtack");
	if (n_wr != 0)
		report_value("mem_size ram_wr above 512k", 32'd0, n_wr);
	bus_cycle(24'hfc0000, 1'b1, 16'h0000, 8, ok, r);
	if (!ok)
		report_fail("rom read at 0xfc0000 got no dtack");
	bus_cycle(24'hfc0000, 1'b0, 16'h5678, 64, ok, r);
	if (ok)
		report_fail("rom write at 0xfc0000 was acknowledged");
	if (!seen_berr)
		report_fail("rom write at 0xfc0000 did not end in a bus error");
	clear_berr();
endtask

task automatic io_decode();
	logic [15:0] r;
	logic        ok;
	string       name;
	for (int i = 0; i < 6; i++) begin
		name = $sformatf("io_decode device %0d", i);
		bus_cycle(io_addr(i), 1'b1, 16'h0000, 8, ok, r);
		if (!ok)
			report_fail($sformatf("%s got no dtack", name));
		if (sel_seen !== (6'b000001 << i))
			report_value(name, 32'(6'b000001 << i), 32'(sel_seen));
		if (n_sel != 1)
			report_value({name, " select cycles"}, 32'd1, n_sel);
		if (r !== periph_value(i))
			report_value({name, " read data"}, 32'(periph_value(i)), 32'(r));
	end
endtask

task automatic bus_error_recovery();
	logic [31:0] rnd;
	logic [23:0] a;
	logic [15:0] r;
	logic        ok;
	bus_cycle(24'hff8a00, 1'b1, 16'h0000, 64, ok, r); // no blitter here
	if (ok)
		report_fail("dtack for 0xff8a00 where no device answers");
	if (!seen_berr)
		report_fail("no bus error within the wait limit for 0xff8a00");
	clear_berr();
	rnd = $urandom;
	a   = rnd[23:0] & 24'h3ffffe;
	bus_cycle(a, 1'b1, 16'h0000, 8, ok, r);
	if (!ok)
		report_fail("no dtack on the cycle after the bus error");
	if (r !== ram_pattern(a[23:1]))
		report_value("bus_error read after clear", 32'(ram_pattern(a[23:1])), 32'(r));
endtask

task automatic interrupt_levels();
	logic [15:0] r;
	logic        ok;
	@(negedge clk_8);
	vs = 1'b1;
	wait_ipl(3'b011, "interrupt vbi level");
	vs = 1'b0;
	bus_cycle(24'hfffff8, 1'b1, 16'h0000, 8, ok, r); // iack level 4
	if (!ok)
		report_fail("level 4 iack got no dtack");
	if (r !== 16'h001c)
		report_value("interrupt vbi vector", 32'h1c, 32'(r));
	wait_ipl(3'b111, "interrupt vbi cleared");
	hs = 1'b1;
	wait_ipl(3'b101, "interrupt hbi level");
	hs = 1'b0;
	bus_cycle(24'hfffff4, 1'b1, 16'h0000, 8, ok, r); // iack level 2
	if (!ok)
		report_fail("level 2 iack got no dtack");
	if (r !== 16'h001a)
		report_value("interrupt hbi vector", 32'h1a, 32'(r));
	wait_ipl(3'b111, "interrupt hbi cleared");
	mfp_irq = 1'b1;
	wait_ipl(3'b001, "interrupt mfp level");
	bus_cycle(24'hfffffc, 1'b1, 16'h0000, 8, ok, r); // iack level 6
	if (!ok)
		report_fail("level 6 iack got no dtack");
	if (n_iack != 1)
		report_value("interrupt mfp_iack pulses", 32'd1, n_iack);
	mfp_irq = 1'b0;
	wait_ipl(3'b111, "interrupt mfp released");
endtask

task automatic bus_request_hold();
	logic [31:0] rnd;
	logic [23:0] a;
	logic [15:0] r;
	logic        ok;
	@(negedge clk_8);
	br  = 1'b1;
	rnd = $urandom;
	a   = rnd[23:0] & 24'h3ffffe;
	start_cycle(a, 1'b1, 16'h0000);
	wait_ack(12, ok, r); // three frames under br
	if (ok)
		report_fail("dtack while br was high");
	if (seen_berr)
		report_fail("bus error while br was high");
	if (n_rd != 0)
		report_value("bus_request ram_rd under br", 32'd0, n_rd);
	br = 1'b0;
	wait_ack(8, ok, r); // same cycle, as_n still low
	if (!ok)
		report_fail("held cycle not answered after br fell");
	if (r !== ram_pattern(a[23:1]))
		report_value("bus_request read data", 32'(ram_pattern(a[23:1])), 32'(r));
	end_cycle();
endtask

// File: bench/tb_st_glue.sv
//##########################################################################
// testbench of the st bus glue, ram pattern model and fixed io read data
// runs the directed tests of tb_tasks.svh and ends with a summary line
//##########################################################################
`timescale 1ns/100ps

module tb_st_glue import st_pkg::*; ();

	logic              clk_8;
	logic              pll_locked;
	logic [addr_w-1:0] cpu_addr;
	logic              cpu_as_n;
	logic              cpu_uds_n;
	logic              cpu_lds_n;
	logic              cpu_rw;
	logic [data_w-1:0] cpu_wdata;
	logic [data_w-1:0] cpu_rdata;
	logic              dtack_n;
	logic              berr;
	logic              clr_berr;
	logic [2:0]        ipl;
	logic [2:0]        mem_cfg;
	logic              br;
	logic              ram_rd;
	logic              ram_wr;
	logic [data_w-1:0] ram_rdata;
	logic              sel_mmu;
	logic              sel_vreg;
	logic              sel_dma;
	logic              sel_psg;
	logic              sel_mfp;
	logic              sel_acia;
	logic [data_w-1:0] io_rdata;
	logic              mfp_irq;
	logic              mfp_iack;
	logic              vs;
	logic              hs;
	logic [5:0]        sel_vec; // mmu in bit 0 up to acia in bit 5

	// what one bus cycle did, cleared by start_cycle
	int         n_wr;
	int         n_rd;
	int         n_sel;
	int         n_iack;
	logic [5:0] sel_seen;
	logic       seen_berr;

	int val_errs;   // wrong values
	int other_errs; // timeouts and protocol trouble

	// read data of the ram model, every address bit takes part
	function automatic logic [15:0] ram_pattern(input logic [22:0] a);
		return {a[7:0], a[15:8]} ^ {9'h000, a[22:16]} ^ 16'hc3a5;
	endfunction

	// fixed read data of each peripheral
	function automatic logic [15:0] periph_value(input int i);
		case (i)
			0:       return 16'h0a01; // mmu
			1:       return 16'h1b02; // video regs
			2:       return 16'h2c04; // dma
			3:       return 16'h3d08; // psg
			4:       return 16'h4e10; // mfp
			default: return 16'h5f20; // acia
		endcase
	endfunction

	st_glue UUT (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.cpu_addr   (cpu_addr),
		.cpu_as_n   (cpu_as_n),
		.cpu_uds_n  (cpu_uds_n),
		.cpu_lds_n  (cpu_lds_n),
		.cpu_rw     (cpu_rw),
		.cpu_wdata  (cpu_wdata),
		.cpu_rdata  (cpu_rdata),
		.dtack_n    (dtack_n),
		.berr       (berr),
		.clr_berr   (clr_berr),
		.ipl        (ipl),
		.mem_cfg    (mem_cfg),
		.br         (br),
		.ram_rd     (ram_rd),
		.ram_wr     (ram_wr),
		.ram_rdata  (ram_rdata),
		.sel_mmu    (sel_mmu),
		.sel_vreg   (sel_vreg),
		.sel_dma    (sel_dma),
		.sel_psg    (sel_psg),
		.sel_mfp    (sel_mfp),
		.sel_acia   (sel_acia),
		.io_rdata   (io_rdata),
		.mfp_irq    (mfp_irq),
		.mfp_iack   (mfp_iack),
		.vs         (vs),
		.hs         (hs)
	);

	assign sel_vec   = {sel_acia, sel_mfp, sel_psg, sel_dma, sel_vreg, sel_mmu};
	assign ram_rdata = ram_pattern(cpu_addr); // no storage, pattern only

	// peripherals drive a shared or'ed read bus
	always_comb begin
		io_rdata = 16'h0000;
		for (int i = 0; i < 6; i++)
			if (sel_vec[i])
				io_rdata |= periph_value(i);
	end

	initial begin
		clk_8 = 1'b0;
		forever #50 clk_8 = ~clk_8; // 8 mhz stand-in, 100 ns
	end

	`include "tb_tasks.svh"

	initial begin
		void'($urandom(14118));
		val_errs   = 0;
		other_errs = 0;
		n_wr       = 0;
		n_rd       = 0;
		n_sel      = 0;
		n_iack     = 0;
		sel_seen   = 6'b000000;
		seen_berr  = 1'b0;
		pll_locked = 1'b0;
		cpu_addr   = '0;
		cpu_as_n   = 1'b1;
		cpu_uds_n  = 1'b1;
		cpu_lds_n  = 1'b1;
		cpu_rw     = 1'b1;
		cpu_wdata  = 16'h0000;
		clr_berr   = 1'b0;
		mem_cfg    = mem_14m;
		br         = 1'b0;
		mfp_irq    = 1'b0;
		vs         = 1'b0;
		hs         = 1'b0;

		repeat (15) @(negedge clk_8);
		reset_state();
		@(negedge clk_8);
		pll_locked = 1'b1; // 16 cycles in reset
		repeat (4) @(negedge clk_8);

		ram_access();
		mem_size_and_rom();
		io_decode();
		bus_error_recovery();
		interrupt_levels();
		bus_request_hold();

		repeat (4) @(negedge clk_8);
		$display("errors: %0d wrong values, %0d other failures", val_errs, other_errs);
		if (val_errs + other_errs == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// last line of defence, the per wait limits should end the run first
	initial begin
		#1000000;
		$display("run did not finish within 1 ms of simulated time");
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: project.f
+incdir+include
source/st_pkg.sv
source/st_bus_if.sv
source/slot_sequencer.sv
source/addr_decode.sv
source/bus_response.sv
source/irq_ctrl.sv
source/st_glue.sv
bench/tb_st_glue.sv

// File: run_sim.sh
#!/bin/sh
# compile the st glue testbench with verilator, run it, judge by the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f project.f --top-module tb_st_glue -o tb_st_glue
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_st_glue > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
	exit 0
fi
echo "pass message missing from $LOG"
exit 1
